//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cache_tb -o cache_sim || exit 1

# keep running past protocol errors so the testbench reports them itself
out=$(./obj_dir/cache_sim +verilator+error+limit+1000)
echo "$out"

echo "$out" | grep -qx "TEST PASSED" && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

//--- verif/cache_props.sv
`timescale 1ns/1ps
`default_nettype none

module cache_props (
  input logic             clk,
  input logic             rst_n,
  input logic             psel,
  input logic             penable,
  input logic             pwrite,
  input cache_pkg::addr_t paddr,
  input cache_pkg::word_t pwdata,
  input logic             pready,
  input logic             mem_req_val,
  input logic             mem_req_rdy,
  input logic             mem_req_write,
  input cache_pkg::addr_t mem_req_addr,
  input cache_pkg::line_t mem_req_data
);

  int unsigned fail_cnt = 0;

  // master holds the access phase until pready
  apb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && !pready) |=>
      (psel && penable && $stable(pwrite) && $stable(paddr) && $stable(pwdata)))
    else begin
      $error("apb master signals changed before pready");
      fail_cnt++;
    end

  mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_val && !mem_req_rdy) |=>
      (mem_req_val && $stable(mem_req_write) && $stable(mem_req_addr)
       && $stable(mem_req_data)))
    else begin
      $error("memory request changed before it was accepted");
      fail_cnt++;
    end

  pready_phase: assert property (@(posedge clk) disable iff (!rst_n)
    pready |-> (psel && penable))
    else begin
      $error("pready high outside an access phase");
      fail_cnt++;
    end

  mem_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !mem_req_val)
    else begin
      $error("memory request raised during reset");
      fail_cnt++;
    end

endmodule

bind blocking_cache cache_props props_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .psel          (psel),
  .penable       (penable),
  .pwrite        (pwrite),
  .paddr         (paddr),
  .pwdata        (pwdata),
  .pready        (pready),
  .mem_req_val   (mem_req_val),
  .mem_req_rdy   (mem_req_rdy),
  .mem_req_write (mem_req_write),
  .mem_req_addr  (mem_req_addr),
  .mem_req_data  (mem_req_data)
);

`default_nettype wire

//--- verif/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  // transfers issued by all tests together set the watchdog limit
  localparam int xfer_total = 2 + 3 + 4 + 4 + 300;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  mem_req_val;
  logic  mem_req_rdy;
  logic  mem_req_write;
  addr_t mem_req_addr;
  line_t mem_req_data;
  logic  mem_resp_val;
  line_t mem_resp_data;

  line_t mem_lines [addr_t];
  word_t shadow [addr_t];
  addr_t wlog_addr [$];
  line_t wlog_data [$];
  int    n_mem_rd;
  int    n_mem_wr;
  int    seed;
  string cur_test;
  int    test_errs;
  int    total_errs;
  int    tests_run;
  int    tests_failed;

  blocking_cache dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_write (mem_req_write),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_data (mem_resp_data)
  );

  always #4 clk = ~clk;

  function automatic word_t pattern_word(input addr_t a);
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic line_t backing_line(input addr_t a);
    line_t l;
    if (mem_lines.exists(a)) begin
      return mem_lines[a];
    end
    for (int i = 0; i < 4; i++) begin
      l[32*i +: 32] = pattern_word(a + addr_t'(4 * i));
    end
    return l;
  endfunction

  function automatic word_t expected_word(input addr_t a);
    return shadow.exists(a) ? shadow[a] : pattern_word(a);
  endfunction

  function automatic line_t expected_line(input addr_t a);
    line_t l;
    for (int i = 0; i < 4; i++) begin
      l[32*i +: 32] = expected_word(a + addr_t'(4 * i));
    end
    return l;
  endfunction

  task automatic check_word(input string what, input word_t exp, input word_t got);
    assert (got === exp) else begin
      $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic check_line(input string what, input line_t exp, input line_t got);
    assert (got === exp) else begin
      $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic check_count(input string what, input int exp, input int got);
    assert (got == exp) else begin
      $display("Mismatch in %s (%s): expected %0d, actual %0d", cur_test, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    tests_run++;
  endtask

  // setup phase, then access phase until pready
  task automatic run_transfer(input logic wr, input addr_t a, input word_t wd,
                              output word_t rd, output int cycles);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = wd;
    @(posedge clk);
    #1;
    penable = 1'b1;
    cycles  = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!pready);
    rd = prdata;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input addr_t a, input word_t d, output int cycles);
    word_t ignored;
    run_transfer(1'b1, a, d, ignored, cycles);
    shadow[a] = d;
  endtask

  task automatic apb_read(input addr_t a, output word_t d, output int cycles);
    run_transfer(1'b0, a, '0, d, cycles);
  endtask

  task automatic read_miss_then_hit();
    word_t d;
    int    cyc;
    int    rd0;
    start_test("read_miss_then_hit");
    rd0 = n_mem_rd;
    apb_read(32'h0000_1040, d, cyc);
    check_word("miss data", pattern_word(32'h0000_1040), d);
    check_count("refills on miss", rd0 + 1, n_mem_rd);
    rd0 = n_mem_rd;
    apb_read(32'h0000_1044, d, cyc);
    check_word("hit data", pattern_word(32'h0000_1044), d);
    check_count("access cycles on hit", 2, cyc);
    check_count("refills on hit", rd0, n_mem_rd);
    finish_test();
  endtask

  task automatic write_allocate();
    word_t d;
    int    cyc;
    int    rd0;
    int    wr0;
    start_test("write_allocate");
    rd0 = n_mem_rd;
    wr0 = n_mem_wr;
    apb_write(32'h0000_2058, 32'hcafe_0001, cyc);
    check_count("refills on write miss", rd0 + 1, n_mem_rd);
    apb_read(32'h0000_2058, d, cyc);
    check_word("written word", 32'hcafe_0001, d);
    check_count("access cycles on hit", 2, cyc);
    apb_read(32'h0000_2050, d, cyc);
    check_word("other word", pattern_word(32'h0000_2050), d);
    check_count("memory writes", wr0, n_mem_wr);
    finish_test();
  endtask

  task automatic two_tags_one_set();
    word_t d;
    int    cyc;
    int    rd0;
    start_test("two_tags_one_set");
    apb_read(32'h0000_3020, d, cyc);
    check_word("first tag", pattern_word(32'h0000_3020), d);
    apb_read(32'h0000_4020, d, cyc);
    check_word("second tag", pattern_word(32'h0000_4020), d);
    rd0 = n_mem_rd;
    apb_read(32'h0000_3024, d, cyc);
    check_word("first tag again", pattern_word(32'h0000_3024), d);
    check_count("access cycles first tag", 2, cyc);
    apb_read(32'h0000_4028, d, cyc);
    check_word("second tag again", pattern_word(32'h0000_4028), d);
    check_count("access cycles second tag", 2, cyc);
    check_count("refills on rereads", rd0, n_mem_rd);
    finish_test();
  endtask

  task automatic dirty_eviction();
    word_t d;
    int    cyc;
    int    wr0;
    int    rd0;
    start_test("dirty_eviction");
    wr0 = n_mem_wr;
    apb_write(32'h0000_5060, 32'h1234_5678, cyc);
    apb_read(32'h0000_6064, d, cyc);
    // set 6 is full now and its dirty line is the LRU one
    apb_read(32'h0000_7068, d, cyc);
    check_word("third tag", pattern_word(32'h0000_7068), d);
    check_count("writebacks", wr0 + 1, n_mem_wr);
    if (wlog_addr.size() > 0) begin
      check_word("writeback address", 32'h0000_5060, wlog_addr[$]);
      check_line("writeback data", expected_line(32'h0000_5060), wlog_data[$]);
    end
    rd0 = n_mem_rd;
    apb_read(32'h0000_5060, d, cyc);
    check_word("evicted word", 32'h1234_5678, d);
    check_count("refill of evicted line", rd0 + 1, n_mem_rd);
    check_count("writebacks after clean eviction", wr0 + 1, n_mem_wr);
    finish_test();
  endtask

  // 4 tags per set over 4 sets keep the two ways evicting
  task automatic random_mix();
    word_t d;
    addr_t a;
    int    cyc;
    int    t;
    int    s;
    int    w;
    start_test("random_mix");
    for (int n = 0; n < 300; n++) begin
      t = int'({$random(seed)} % 4);
      s = int'({$random(seed)} % 4);
      w = int'({$random(seed)} % 4);
      a = 32'h0001_0000 + addr_t'(t * 128 + s * 16 + w * 4);
      if ({$random(seed)} % 2 == 0) begin
        d = $random(seed);
        apb_write(a, d, cyc);
      end else begin
        apb_read(a, d, cyc);
        check_word("read data", expected_word(a), d);
      end
    end
    finish_test();
  endtask

  // line memory with random accept stalls and a 2 to 5 cycle read latency
  initial begin
    int    stall;
    int    lat;
    addr_t req_addr;
    line_t req_data;
    logic  req_write;
    mem_req_rdy   = 1'b0;
    mem_resp_val  = 1'b0;
    mem_resp_data = '0;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (mem_req_val) begin
        stall = int'({$random(seed)} % 4);
        repeat (stall) @(negedge clk);
        @(posedge clk);
        #1;
        mem_req_rdy = 1'b1;
        @(negedge clk);
        req_addr  = mem_req_addr;
        req_data  = mem_req_data;
        req_write = mem_req_write;
        @(posedge clk);
        #1;
        mem_req_rdy = 1'b0;
        if (req_write) begin
          mem_lines[req_addr] = req_data;
          wlog_addr.push_back(req_addr);
          wlog_data.push_back(req_data);
          n_mem_wr++;
        end else begin
          n_mem_rd++;
          lat = 2 + int'({$random(seed)} % 4);
          repeat (lat - 1) @(posedge clk);
          #1;
          mem_resp_val  = 1'b1;
          mem_resp_data = backing_line(req_addr);
          @(posedge clk);
          #1;
          mem_resp_val = 1'b0;
        end
      end
    end
  end

  initial begin
    repeat (10 + 200 * xfer_total) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", 10 + 200 * xfer_total);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    seed         = 32'h218a;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    n_mem_rd     = 0;
    n_mem_wr     = 0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    read_miss_then_hit();
    write_allocate();
    two_tags_one_set();
    dirty_eviction();
    random_mix();
    start_test("protocol");
    assert (dut_i.props_i.fail_cnt == 0) else begin
      $display("the protocol checker saw %0d assertion failures", dut_i.props_i.fail_cnt);
      test_errs++;
    end
    finish_test();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/blocking_cache.sv
`timescale 1ns/1ps
`default_nettype none

module blocking_cache (
  input  logic             clk,
  input  logic             rst_n,
  // APB slave
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  cache_pkg::addr_t paddr,
  input  cache_pkg::word_t pwdata,
  output cache_pkg::word_t prdata,
  output logic             pready,
  // line memory
  output logic             mem_req_val,
  input  logic             mem_req_rdy,
  output logic             mem_req_write,
  output cache_pkg::addr_t mem_req_addr,
  output cache_pkg::line_t mem_req_data,
  input  logic             mem_resp_val,
  input  cache_pkg::line_t mem_resp_data
);
  import cache_pkg::*;

  logic  way_sel;
  logic  resp_en;
  logic  refill_en;
  logic  merge_store;
  logic  mem_addr_sel;
  line_t wr_line;

  way_ctrl_if w0_if ();
  way_ctrl_if w1_if ();

  cache_ctrl ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pready        (pready),
    .paddr         (paddr),
    .w0            (w0_if),
    .w1            (w1_if),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_write (mem_req_write),
    .mem_resp_val  (mem_resp_val),
    .way_sel       (way_sel),
    .resp_en       (resp_en),
    .refill_en     (refill_en),
    .merge_store   (merge_store),
    .mem_addr_sel  (mem_addr_sel)
  );

  cache_way way0_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .way     (w0_if),
    .addr    (paddr),
    .wr_line (wr_line)
  );

  cache_way way1_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .way     (w1_if),
    .addr    (paddr),
    .wr_line (wr_line)
  );

  line_datapath dpath_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .way_sel       (way_sel),
    .resp_en       (resp_en),
    .refill_en     (refill_en),
    .merge_store   (merge_store),
    .mem_addr_sel  (mem_addr_sel),
    .line0         (w0_if.rd_line),
    .line1         (w1_if.rd_line),
    .evict0        (w0_if.evict_addr),
    .evict1        (w1_if.evict_addr),
    .mem_resp_data (mem_resp_data),
    .wr_line       (wr_line),
    .prdata        (prdata),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data)
  );

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  output logic             pready,
  input  cache_pkg::addr_t paddr,
  way_ctrl_if.ctrl         w0,
  way_ctrl_if.ctrl         w1,
  output logic             mem_req_val,
  input  logic             mem_req_rdy,
  output logic             mem_req_write,
  input  logic             mem_resp_val,
  output logic             way_sel,
  output logic             resp_en,
  output logic             refill_en,
  output logic             merge_store,
  output logic             mem_addr_sel
);
  import cache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  idx_t  idx;
  woff_t woff;
  logic  any_hit;
  logic  victim;
  logic  victim_dirty;
  logic  tgt;
  logic  way_q;
  logic  hit_q;

  logic [`CACHE_SETS-1:0] lru_q;

  logic                         tag_ren_c;
  logic                         tag_wen_c;
  logic                         data_ren_c;
  logic                         data_wen_c;
  logic                         set_dirty_c;
  logic                         evict_en_c;
  logic [`CACHE_LINE_BYTES-1:0] wben_c;
  logic [`CACHE_LINE_BYTES-1:0] word_ben;

  assign idx  = paddr[`CACHE_LINE_OFF_W +: `CACHE_IDX_W];
  assign woff = paddr[`CACHE_BOFF_W +: `CACHE_OFF_W];

  assign any_hit = w0.hit | w1.hit;

  // empty way first, way 0 before way 1, then the LRU way
  always_comb begin
    if (!w0.valid) begin
      victim = 1'b0;
    end else if (!w1.valid) begin
      victim = 1'b1;
    end else begin
      victim = lru_q[idx];
    end
  end

  assign victim_dirty = victim ? w1.dirty : w0.dirty;

  always_comb begin
    state_nxt = state;
    case (state)
      idle:        if (psel && !penable) state_nxt = lookup;
      lookup: begin
        if (any_hit) begin
          state_nxt = respond;
        end else if (victim_dirty) begin
          state_nxt = writeback;
        end else begin
          state_nxt = refill_req;
        end
      end
      writeback:   if (mem_req_rdy) state_nxt = refill_req;
      refill_req:  if (mem_req_rdy) state_nxt = refill_wait;
      refill_wait: if (mem_resp_val) state_nxt = fill;
      fill:        state_nxt = respond;
      respond:     state_nxt = idle;
      default:     state_nxt = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  // remember which way this transfer works on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      way_q <= 1'b0;
      hit_q <= 1'b0;
    end else if (state == lookup) begin
      way_q <= any_hit ? w1.hit : victim;
      hit_q <= any_hit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lru_q <= '0;
    end else if (state == respond) begin
      lru_q[idx] <= ~way_q;
    end
  end

  always_comb begin
    word_ben = '0;
    word_ben[woff*`CACHE_WORD_BYTES +: `CACHE_WORD_BYTES] = '1;
  end

  always_comb begin
    tag_ren_c   = 1'b0;
    tag_wen_c   = 1'b0;
    data_ren_c  = 1'b0;
    data_wen_c  = 1'b0;
    set_dirty_c = 1'b0;
    evict_en_c  = 1'b0;
    wben_c      = '0;
    case (state)
      lookup: begin
        tag_ren_c  = 1'b1;
        data_ren_c = any_hit;
        evict_en_c = !any_hit;
      end
      writeback: data_ren_c = 1'b1;
      fill: begin
        tag_wen_c   = 1'b1;
        data_wen_c  = 1'b1;
        wben_c      = '1;
        set_dirty_c = pwrite;
      end
      respond: begin
        // store hit commits here, a store miss was merged during fill
        if (hit_q && pwrite) begin
          data_wen_c  = 1'b1;
          wben_c      = word_ben;
          set_dirty_c = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign tgt = (state == lookup) ? (any_hit ? w1.hit : victim) : way_q;

  // both tags are compared, everything else goes to one way
  assign w0.tag_ren       = tag_ren_c;
  assign w1.tag_ren       = tag_ren_c;
  assign w0.tag_wen       = tag_wen_c & ~tgt;
  assign w1.tag_wen       = tag_wen_c & tgt;
  assign w0.data_ren      = data_ren_c & ~tgt;
  assign w1.data_ren      = data_ren_c & tgt;
  assign w0.data_wen      = data_wen_c & ~tgt;
  assign w1.data_wen      = data_wen_c & tgt;
  assign w0.data_wben     = tgt ? '0 : wben_c;
  assign w1.data_wben     = tgt ? wben_c : '0;
  assign w0.set_dirty     = set_dirty_c & ~tgt;
  assign w1.set_dirty     = set_dirty_c & tgt;
  assign w0.evict_addr_en = evict_en_c & ~tgt;
  assign w1.evict_addr_en = evict_en_c & tgt;

  assign way_sel      = tgt;
  assign pready       = (state == respond);
  assign resp_en      = ((state == lookup) && any_hit) || (state == fill);
  assign refill_en    = (state == refill_wait) && mem_resp_val;
  assign merge_store  = (state == fill) && pwrite;
  assign mem_req_val  = (state == writeback) || (state == refill_req);
  assign mem_req_write = (state == writeback);
  assign mem_addr_sel = (state != writeback);

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

  typedef logic [`CACHE_ADDR_W-1:0] addr_t;
  typedef logic [`CACHE_WORD_W-1:0] word_t;
  typedef logic [`CACHE_LINE_W-1:0] line_t;

  typedef logic [`CACHE_TAG_W-1:0] tag_t;
  typedef logic [`CACHE_IDX_W-1:0] idx_t;
  typedef logic [`CACHE_OFF_W-1:0] woff_t;

  // controller states for one APB transfer at a time
  typedef enum logic [2:0] {
    idle,
    lookup,
    respond,
    writeback,
    refill_req,
    refill_wait,
    fill
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// base geometry
`define CACHE_ADDR_W     32
`define CACHE_WORD_W     32
`define CACHE_LINE_W     128
`define CACHE_WAY_BYTES  128

// derived sizes
`define CACHE_SETS       (`CACHE_WAY_BYTES * 8 / `CACHE_LINE_W)
`define CACHE_LINE_BYTES (`CACHE_LINE_W / 8)
`define CACHE_WORD_BYTES (`CACHE_WORD_W / 8)

// address split into tag, index, word offset and byte offset
`define CACHE_IDX_W      ($clog2(`CACHE_SETS))
`define CACHE_OFF_W      ($clog2(`CACHE_LINE_W / `CACHE_WORD_W))
`define CACHE_BOFF_W     ($clog2(`CACHE_WORD_BYTES))
`define CACHE_LINE_OFF_W (`CACHE_OFF_W + `CACHE_BOFF_W)
`define CACHE_TAG_W      (`CACHE_ADDR_W - `CACHE_IDX_W - `CACHE_LINE_OFF_W)

`endif

//--- verilog/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_way (
  input  logic             clk,
  input  logic             rst_n,
  way_ctrl_if.way          way,
  input  cache_pkg::addr_t addr,
  input  cache_pkg::line_t wr_line
);
  import cache_pkg::*;

  tag_t  tag;
  idx_t  idx;
  tag_t  rd_tag;
  line_t rd_data;
  addr_t evict_q;

  tag_t                   tag_mem  [`CACHE_SETS];
  line_t                  data_mem [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_q;
  logic [`CACHE_SETS-1:0] dirty_q;

  assign tag = addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign idx = addr[`CACHE_LINE_OFF_W +: `CACHE_IDX_W];

  // arrays read combinationally at the request index
  assign rd_tag  = tag_mem[idx];
  assign rd_data = data_mem[idx];

  assign way.valid = valid_q[idx];
  assign way.dirty = dirty_q[idx];

  // tag compare only counts while the controller looks the tag up
  assign way.hit        = way.tag_ren && valid_q[idx] && (rd_tag == tag);
  assign way.rd_line    = way.data_ren ? rd_data : '0;
  assign way.evict_addr = evict_q;

  always_ff @(posedge clk) begin
    if (way.tag_wen) begin
      tag_mem[idx] <= tag;
    end
  end

  always_ff @(posedge clk) begin
    if (way.data_wen) begin
      for (int b = 0; b < `CACHE_LINE_BYTES; b++) begin
        if (way.data_wben[b]) begin
          data_mem[idx][8*b +: 8] <= wr_line[8*b +: 8];
        end
      end
    end
  end

  // a tag write always installs a fresh line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (way.tag_wen) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // fill of a read clears dirty, any store sets it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dirty_q <= '0;
    end else if (way.data_wen) begin
      dirty_q[idx] <= way.set_dirty;
    end
  end

  // victim line address rebuilt from the stored tag
  always_ff @(posedge clk) begin
    if (way.evict_addr_en) begin
      evict_q <= {rd_tag, idx, {`CACHE_LINE_OFF_W{1'b0}}};
    end
  end

endmodule

`default_nettype wire

//--- verilog/line_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module line_datapath (
  input  logic             clk,
  input  logic             rst_n,
  input  cache_pkg::addr_t paddr,
  input  cache_pkg::word_t pwdata,
  input  logic             way_sel,
  input  logic             resp_en,
  input  logic             refill_en,
  input  logic             merge_store,
  input  logic             mem_addr_sel,
  input  cache_pkg::line_t line0,
  input  cache_pkg::line_t line1,
  input  cache_pkg::addr_t evict0,
  input  cache_pkg::addr_t evict1,
  input  cache_pkg::line_t mem_resp_data,
  output cache_pkg::line_t wr_line,
  output cache_pkg::word_t prdata,
  output cache_pkg::addr_t mem_req_addr,
  output cache_pkg::line_t mem_req_data
);
  import cache_pkg::*;

  woff_t woff;
  line_t refill_q;
  logic  refill_fresh;
  line_t merged;
  line_t bcast;
  line_t way_line;
  line_t rd_src;
  addr_t evict_addr;
  addr_t line_addr;

  assign woff = paddr[`CACHE_BOFF_W +: `CACHE_OFF_W];

  always_ff @(posedge clk) begin
    if (refill_en) begin
      refill_q <= mem_resp_data;
    end
  end

  // set once a refill line arrives, dropped when the response is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refill_fresh <= 1'b0;
    end else if (refill_en) begin
      refill_fresh <= 1'b1;
    end else if (resp_en) begin
      refill_fresh <= 1'b0;
    end
  end

  always_comb begin
    merged = refill_q;
    if (merge_store) begin
      merged[woff*`CACHE_WORD_W +: `CACHE_WORD_W] = pwdata;
    end
  end

  // on a hit store the byte enables pick the word out of the copies
  assign bcast   = {(`CACHE_LINE_W / `CACHE_WORD_W){pwdata}};
  assign wr_line = refill_fresh ? merged : bcast;

  assign way_line = way_sel ? line1 : line0;
  assign rd_src   = refill_fresh ? refill_q : way_line;

  always_ff @(posedge clk) begin
    if (resp_en) begin
      prdata <= rd_src[woff*`CACHE_WORD_W +: `CACHE_WORD_W];
    end
  end

  assign evict_addr = way_sel ? evict1 : evict0;
  assign line_addr  = {paddr[`CACHE_ADDR_W-1:`CACHE_LINE_OFF_W], {`CACHE_LINE_OFF_W{1'b0}}};

  assign mem_req_addr = mem_addr_sel ? line_addr : evict_addr;
  assign mem_req_data = way_line;

endmodule

`default_nettype wire

//--- verilog/way_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

interface way_ctrl_if;
  import cache_pkg::*;

  // control from the FSM
  logic                         tag_ren;
  logic                         tag_wen;
  logic                         data_ren;
  logic                         data_wen;
  logic [`CACHE_LINE_BYTES-1:0] data_wben;
  logic                         set_dirty;
  logic                         evict_addr_en;

  // status and data back from the way
  logic  hit;
  logic  valid;
  logic  dirty;
  addr_t evict_addr;
  line_t rd_line;

  modport ctrl (
    output tag_ren, tag_wen, data_ren, data_wen, data_wben, set_dirty, evict_addr_en,
    input  hit, valid, dirty
  );

  modport way (
    input  tag_ren, tag_wen, data_ren, data_wen, data_wben, set_dirty, evict_addr_en,
    output hit, valid, dirty, evict_addr, rd_line
  );

endinterface

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/way_ctrl_if.sv
verilog/cache_way.sv
verilog/cache_ctrl.sv
verilog/line_datapath.sv
verilog/blocking_cache.sv
verif/cache_props.sv
verif/cache_tb.sv
